//--- all.f
+incdir+source
source/issue_pkg.sv
source/pair_dispatcher.sv
source/reg_file.sv
source/lane_pipe.sv
source/full_pipe.sv
source/dual_issue_core.sv
tb/tb_clock.sv
tb/dual_issue_properties.sv
tb/dual_issue_checker.sv
tb/dual_issue_tb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f all.f --top-module dual_issue_tb -o sim_dual_issue

status=0
./obj_dir/sim_dual_issue > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation log is clean"

//--- source/dual_issue_core.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module dual_issue_core (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   hold,
    input  logic                   old_valid,
    input  issue_pkg::issue_op_t   old_op,
    input  logic [`REG_ADDR_W-1:0] old_rd,
    input  logic [`REG_ADDR_W-1:0] old_rj,
    input  logic [`REG_ADDR_W-1:0] old_rk,
    input  logic [`IMM_W-1:0]      old_imm,
    input  logic                   young_valid,
    input  issue_pkg::issue_op_t   young_op,
    input  logic [`REG_ADDR_W-1:0] young_rd,
    input  logic [`REG_ADDR_W-1:0] young_rj,
    input  logic [`REG_ADDR_W-1:0] young_rk,
    input  logic [`IMM_W-1:0]      young_imm,
    output logic                   accept_old,
    output logic                   accept_young,
    input  logic [`REG_ADDR_W-1:0] dbg_addr,
    output logic [`DATA_W-1:0]     dbg_data
);
    import issue_pkg::*;

    issue_op_t              full_op;
    issue_op_t              lane_op;
    logic [`REG_ADDR_W-1:0] full_rd;
    logic [`REG_ADDR_W-1:0] lane_rd;
    logic [`REG_ADDR_W-1:0] old_b_addr;
    logic [`DATA_W-1:0]     full_a;
    logic [`DATA_W-1:0]     full_b;
    logic [`DATA_W-1:0]     lane_a;
    logic [`DATA_W-1:0]     lane_b;
    logic [`IMM_W-1:0]      full_imm;
    logic [`IMM_W-1:0]      lane_imm;
    logic [`DATA_W-1:0]     old_a;
    logic [`DATA_W-1:0]     old_bd;
    logic [`DATA_W-1:0]     young_a;
    logic [`DATA_W-1:0]     young_b;
    logic                   lane_we;
    logic                   full_we1;
    logic                   full_we2;
    logic [`REG_ADDR_W-1:0] lane_waddr;
    logic [`REG_ADDR_W-1:0] full_waddr1;
    logic [`REG_ADDR_W-1:0] full_waddr2;
    logic [`DATA_W-1:0]     lane_wdata;
    logic [`DATA_W-1:0]     full_wdata1;
    logic [`DATA_W-1:0]     full_wdata2;

    // a store never reads rk, so its rd shares the second older read port
    assign old_b_addr = (old_op == op_st) ? old_rd : old_rk;

    pair_dispatcher i_pair_dispatcher (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .hold         (hold),
        .old_valid    (old_valid),
        .old_op       (old_op),
        .old_rd       (old_rd),
        .old_rj       (old_rj),
        .old_rk       (old_rk),
        .old_imm      (old_imm),
        .young_valid  (young_valid),
        .young_op     (young_op),
        .young_rd     (young_rd),
        .young_rj     (young_rj),
        .young_rk     (young_rk),
        .young_imm    (young_imm),
        .old_a        (old_a),
        .old_b        (old_bd),
        .old_d        (old_bd),
        .young_a      (young_a),
        .young_b      (young_b),
        .accept_old   (accept_old),
        .accept_young (accept_young),
        .full_op      (full_op),
        .full_rd      (full_rd),
        .full_a       (full_a),
        .full_b       (full_b),
        .full_imm     (full_imm),
        .lane_op      (lane_op),
        .lane_rd      (lane_rd),
        .lane_a       (lane_a),
        .lane_b       (lane_b),
        .lane_imm     (lane_imm)
    );

    // port 4 is the debug read
    reg_file i_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr0 (old_rj),
        .raddr1 (old_b_addr),
        .raddr2 (young_rj),
        .raddr3 (young_rk),
        .raddr4 (dbg_addr),
        .rdata0 (old_a),
        .rdata1 (old_bd),
        .rdata2 (young_a),
        .rdata3 (young_b),
        .rdata4 (dbg_data),
        .we0    (lane_we),
        .we1    (full_we1),
        .we2    (full_we2),
        .waddr0 (lane_waddr),
        .waddr1 (full_waddr1),
        .waddr2 (full_waddr2),
        .wdata0 (lane_wdata),
        .wdata1 (full_wdata1),
        .wdata2 (full_wdata2)
    );

    lane_pipe i_lane_pipe (
        .clk      (clk),
        .arst_n   (arst_n),
        .lane_op  (lane_op),
        .lane_rd  (lane_rd),
        .lane_a   (lane_a),
        .lane_b   (lane_b),
        .lane_imm (lane_imm),
        .we       (lane_we),
        .waddr    (lane_waddr),
        .wdata    (lane_wdata)
    );

    full_pipe i_full_pipe (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .full_op  (full_op),
        .full_rd  (full_rd),
        .full_a   (full_a),
        .full_b   (full_b),
        .full_imm (full_imm),
        .we1      (full_we1),
        .waddr1   (full_waddr1),
        .wdata1   (full_wdata1),
        .we2      (full_we2),
        .waddr2   (full_waddr2),
        .wdata2   (full_wdata2)
    );

endmodule

//--- source/full_pipe.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module full_pipe (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  issue_pkg::issue_op_t   full_op,
    input  logic [`REG_ADDR_W-1:0] full_rd,
    input  logic [`DATA_W-1:0]     full_a,
    input  logic [`DATA_W-1:0]     full_b,
    input  logic [`IMM_W-1:0]      full_imm,
    output logic                   we1,
    output logic [`REG_ADDR_W-1:0] waddr1,
    output logic [`DATA_W-1:0]     wdata1,
    output logic                   we2,
    output logic [`REG_ADDR_W-1:0] waddr2,
    output logic [`DATA_W-1:0]     wdata2
);
    import issue_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    logic [`DATA_W-1:0]     dmem [`DMEM_DEPTH];
    logic [`DATA_W-1:0]     s1_addr;
    full_stage_t            s2_stage;
    logic [`REG_ADDR_W-1:0] s2_rd;
    logic [`DATA_W-1:0]     s2_a;
    logic [`DATA_W-1:0]     s2_b;
    logic [DMEM_AW-1:0]     s2_addr;

    // stage 1, single cycle ALU
    assign we1    = is_simple(full_op) && (full_rd != '0);
    assign waddr1 = full_rd;
    assign wdata1 = simple_alu(full_op, full_a, full_b, full_imm);

    assign s1_addr = full_a + sext_imm(full_imm);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_stage <= stage_idle;
        end else if (flush) begin
            s2_stage <= stage_idle;
        end else begin
            case (full_op)
                op_mul:  s2_stage <= stage_mul;
                op_ld:   s2_stage <= stage_ld;
                op_st:   s2_stage <= stage_st;
                default: s2_stage <= stage_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        s2_rd   <= full_rd;
        s2_a    <= full_a;
        s2_b    <= full_b;
        // address wraps modulo memory depth
        s2_addr <= s1_addr[DMEM_AW-1:0];
    end

    // store lands at the end of stage 2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (s2_stage == stage_st) begin
            dmem[s2_addr] <= s2_b;
        end
    end

    // stage 2, low half of product or loaded word
    assign we2    = (s2_stage == stage_mul || s2_stage == stage_ld) && (s2_rd != '0);
    assign waddr2 = s2_rd;
    assign wdata2 = (s2_stage == stage_mul) ? s2_a * s2_b : dmem[s2_addr];

endmodule

//--- source/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// datapath width
`define DATA_W 32

// immediate field, sign-extended to DATA_W
`define IMM_W 12

// data memory words, address wraps modulo depth
`define DMEM_DEPTH 16

`endif

//--- source/issue_pkg.sv
`include "issue_consts.svh"

package issue_pkg;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_mul,
        op_ld,
        op_st
    } issue_op_t;

    // second stage of the full pipe
    typedef enum logic [1:0] {
        stage_idle,
        stage_mul,
        stage_ld,
        stage_st
    } full_stage_t;

    // single cycle ALU ops, legal in either pipe
    function automatic logic is_simple(issue_op_t op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};
    endfunction

    function automatic logic [`DATA_W-1:0] sext_imm(logic [`IMM_W-1:0] imm);
        return {{(`DATA_W - `IMM_W){imm[`IMM_W-1]}}, imm};
    endfunction

    function automatic logic [`DATA_W-1:0] simple_alu(
        issue_op_t           op,
        logic [`DATA_W-1:0]  a,
        logic [`DATA_W-1:0]  b,
        logic [`IMM_W-1:0]   imm
    );
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + sext_imm(imm);
            default: return '0;
        endcase
    endfunction

endpackage

//--- source/lane_pipe.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module lane_pipe (
    input  logic                   clk,
    input  logic                   arst_n,
    input  issue_pkg::issue_op_t   lane_op,
    input  logic [`REG_ADDR_W-1:0] lane_rd,
    input  logic [`DATA_W-1:0]     lane_a,
    input  logic [`DATA_W-1:0]     lane_b,
    input  logic [`IMM_W-1:0]      lane_imm,
    output logic                   we,
    output logic [`REG_ADDR_W-1:0] waddr,
    output logic [`DATA_W-1:0]     wdata
);
    import issue_pkg::*;

    logic live;

    // writes enabled from the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // result is captured by the register file at the end of the issue cycle
    assign we    = live && is_simple(lane_op) && (lane_rd != '0);
    assign waddr = lane_rd;
    assign wdata = simple_alu(lane_op, lane_a, lane_b, lane_imm);

endmodule

//--- source/pair_dispatcher.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module pair_dispatcher (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   hold,
    input  logic                   old_valid,
    input  issue_pkg::issue_op_t   old_op,
    input  logic [`REG_ADDR_W-1:0] old_rd,
    input  logic [`REG_ADDR_W-1:0] old_rj,
    input  logic [`REG_ADDR_W-1:0] old_rk,
    input  logic [`IMM_W-1:0]      old_imm,
    input  logic                   young_valid,
    input  issue_pkg::issue_op_t   young_op,
    input  logic [`REG_ADDR_W-1:0] young_rd,
    input  logic [`REG_ADDR_W-1:0] young_rj,
    input  logic [`REG_ADDR_W-1:0] young_rk,
    input  logic [`IMM_W-1:0]      young_imm,
    input  logic [`DATA_W-1:0]     old_a,
    input  logic [`DATA_W-1:0]     old_b,
    input  logic [`DATA_W-1:0]     old_d,
    input  logic [`DATA_W-1:0]     young_a,
    input  logic [`DATA_W-1:0]     young_b,
    output logic                   accept_old,
    output logic                   accept_young,
    output issue_pkg::issue_op_t   full_op,
    output logic [`REG_ADDR_W-1:0] full_rd,
    output logic [`DATA_W-1:0]     full_a,
    output logic [`DATA_W-1:0]     full_b,
    output logic [`IMM_W-1:0]      full_imm,
    output issue_pkg::issue_op_t   lane_op,
    output logic [`REG_ADDR_W-1:0] lane_rd,
    output logic [`DATA_W-1:0]     lane_a,
    output logic [`DATA_W-1:0]     lane_b,
    output logic [`IMM_W-1:0]      lane_imm
);
    import issue_pkg::*;

    // destination of the two-cycle op issued last cycle, zero when none
    logic [`REG_ADDR_W-1:0] pend_rd;
    logic                   old_stall;
    logic                   young_stall;
    logic                   young_dep;

    // true if op reads register r, r0 never counts
    function automatic logic reads_reg(
        issue_op_t              op,
        logic [`REG_ADDR_W-1:0] rd,
        logic [`REG_ADDR_W-1:0] rj,
        logic [`REG_ADDR_W-1:0] rk,
        logic [`REG_ADDR_W-1:0] r
    );
        logic uses_rj;
        logic uses_rk;
        logic uses_rd;
        uses_rj = (op != op_nop);
        uses_rk = op inside {op_add, op_sub, op_and, op_or, op_xor, op_mul};
        // store data comes from rd
        uses_rd = (op == op_st);
        return (r != '0) && ((uses_rj && rj == r) || (uses_rk && rk == r) ||
                             (uses_rd && rd == r));
    endfunction

    assign old_stall   = reads_reg(old_op, old_rd, old_rj, old_rk, pend_rd);
    assign young_stall = reads_reg(young_op, young_rd, young_rj, young_rk, pend_rd);

    // younger may neither read nor overwrite the older rd
    assign young_dep = reads_reg(young_op, young_rd, young_rj, young_rk, old_rd) ||
                       ((old_rd != '0) && (young_rd == old_rd));

    assign accept_old   = old_valid && !hold && !old_stall;
    assign accept_young = accept_old && young_valid && is_simple(young_op) &&
                          !young_stall && !young_dep;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_rd <= '0;
        end else if (flush) begin
            pend_rd <= '0;
        end else if (accept_old && (old_op == op_mul || old_op == op_ld)) begin
            pend_rd <= old_rd;
        end else begin
            pend_rd <= '0;
        end
    end

    // refused slots go out as nop with zero fields
    always_comb begin
        full_op  = op_nop;
        full_rd  = '0;
        full_a   = '0;
        full_b   = '0;
        full_imm = '0;
        lane_op  = op_nop;
        lane_rd  = '0;
        lane_a   = '0;
        lane_b   = '0;
        lane_imm = '0;
        if (accept_old) begin
            full_op  = old_op;
            full_rd  = old_rd;
            full_a   = old_a;
            full_b   = (old_op == op_st) ? old_d : old_b;
            full_imm = old_imm;
        end
        if (accept_young) begin
            lane_op  = young_op;
            lane_rd  = young_rd;
            lane_a   = young_a;
            lane_b   = young_b;
            lane_imm = young_imm;
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`REG_ADDR_W-1:0] raddr0,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  logic [`REG_ADDR_W-1:0] raddr3,
    input  logic [`REG_ADDR_W-1:0] raddr4,
    output logic [`DATA_W-1:0]     rdata0,
    output logic [`DATA_W-1:0]     rdata1,
    output logic [`DATA_W-1:0]     rdata2,
    output logic [`DATA_W-1:0]     rdata3,
    output logic [`DATA_W-1:0]     rdata4,
    input  logic                   we0,
    input  logic                   we1,
    input  logic                   we2,
    input  logic [`REG_ADDR_W-1:0] waddr0,
    input  logic [`REG_ADDR_W-1:0] waddr1,
    input  logic [`REG_ADDR_W-1:0] waddr2,
    input  logic [`DATA_W-1:0]     wdata0,
    input  logic [`DATA_W-1:0]     wdata1,
    input  logic [`DATA_W-1:0]     wdata2
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // oldest port first, so port 0 lands last and wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we2 && waddr2 != '0) begin
                regs[waddr2] <= wdata2;
            end
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
        end
    end

    // r0 is never written, so it reads zero
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];
    assign rdata4 = regs[raddr4];

endmodule

//--- tb/dual_issue_checker.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module dual_issue_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   hold,
    input  logic                   old_valid,
    input  issue_pkg::issue_op_t   old_op,
    input  logic [`REG_ADDR_W-1:0] old_rd,
    input  logic [`REG_ADDR_W-1:0] old_rj,
    input  logic [`REG_ADDR_W-1:0] old_rk,
    input  logic                   young_valid,
    input  issue_pkg::issue_op_t   young_op,
    input  logic [`REG_ADDR_W-1:0] young_rd,
    input  logic [`REG_ADDR_W-1:0] young_rj,
    input  logic [`REG_ADDR_W-1:0] young_rk,
    input  logic                   accept_old,
    input  logic                   accept_young,
    input  logic [`DATA_W-1:0]     dbg_data,
    output int                     pass_count,
    output int                     fail_count,
    output int                     issue_errs
);
    import issue_pkg::*;

    string                  cur_name = "reset";
    int                     passes = 0;
    int                     fails = 0;
    int                     errs = 0;
    int                     errs_marked = 0;
    // rd of the mul or load accepted last cycle
    logic [`REG_ADDR_W-1:0] pend = '0;
    logic                   exp_old;
    logic                   exp_young;

    assign pass_count = passes;
    assign fail_count = fails;
    assign issue_errs = errs;

    function automatic logic touches(issue_op_t op, logic [`REG_ADDR_W-1:0] rd,
                                     logic [`REG_ADDR_W-1:0] rj,
                                     logic [`REG_ADDR_W-1:0] rk,
                                     logic [`REG_ADDR_W-1:0] r);
        logic hit;
        hit = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_mul: hit = (rj == r) || (rk == r);
            op_addi, op_ld: hit = (rj == r);
            // store data comes from rd
            op_st: hit = (rj == r) || (rd == r);
            default: hit = 1'b0;
        endcase
        return hit && (r != '0);
    endfunction

    function automatic logic lane_ok(issue_op_t op);
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_addi: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    always @(negedge clk) begin
        if (!arst_n) begin
            pend = '0;
        end else begin
            exp_old = old_valid && !hold &&
                      !touches(old_op, old_rd, old_rj, old_rk, pend);
            exp_young = exp_old && young_valid && lane_ok(young_op) &&
                        !touches(young_op, young_rd, young_rj, young_rk, pend) &&
                        !touches(young_op, young_rd, young_rj, young_rk, old_rd) &&
                        !((old_rd != '0) && (young_rd == old_rd));
            if (accept_old !== exp_old) begin
                $display("FAIL %s accept_old expected %0b actual %0b at %0t",
                         cur_name, exp_old, accept_old, $time);
                errs = errs + 1;
            end
            if (accept_young !== exp_young) begin
                $display("FAIL %s accept_young expected %0b actual %0b at %0t",
                         cur_name, exp_young, accept_young, $time);
                errs = errs + 1;
            end
            if (hold && (accept_old || accept_young)) begin
                $display("test %s: an instruction was accepted during hold at %0t",
                         cur_name, $time);
                errs = errs + 1;
            end
            if (!flush && exp_old && (old_op == op_mul || old_op == op_ld)) begin
                pend = old_rd;
            end else begin
                pend = '0;
            end
        end
    end

    task automatic start_test(input string name);
        cur_name = name;
    endtask

    task automatic finish_test(input logic [`REG_ADDR_W-1:0] r,
                               input logic [`DATA_W-1:0] expected);
        int new_errs;
        new_errs = errs - errs_marked;
        errs_marked = errs;
        if (dbg_data !== expected) begin
            $display("FAIL %s r%0d expected %h actual %h", cur_name, r, expected, dbg_data);
            fails = fails + 1;
        end else if (new_errs != 0) begin
            $display("test %s: %0d accept decisions broke the issue rules",
                     cur_name, new_errs);
            fails = fails + 1;
        end else begin
            $display("PASS %s r%0d = %h", cur_name, r, dbg_data);
            passes = passes + 1;
        end
    endtask

endmodule

//--- tb/dual_issue_properties.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module dual_issue_properties (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   hold,
    input logic                   accept_old,
    input logic                   accept_young,
    input logic [`REG_ADDR_W-1:0] full_rd,
    input logic [`REG_ADDR_W-1:0] lane_rd
);

    // lane slot only fills behind the full pipe
    young_needs_old: assert property (@(posedge clk) disable iff (!arst_n)
        accept_young |-> accept_old)
        else $error("accept_young high without accept_old");

    no_issue_on_hold: assert property (@(posedge clk) disable iff (!arst_n)
        hold |-> (!accept_old && !accept_young))
        else $error("instruction accepted while hold is high");

    // r0 may appear in both slots
    distinct_dests: assert property (@(posedge clk) disable iff (!arst_n)
        (accept_young && full_rd != '0) |-> (full_rd != lane_rd))
        else $error("both pipes issued to the same destination");

endmodule

bind pair_dispatcher dual_issue_properties i_dual_issue_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .hold         (hold),
    .accept_old   (accept_old),
    .accept_young (accept_young),
    .full_rd      (full_rd),
    .lane_rd      (lane_rd)
);

//--- tb/dual_issue_tb.sv
`timescale 1ns/1ps
`include "issue_consts.svh"

module dual_issue_tb;
    import issue_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int MAX_INS = 8;
    localparam int TIMEOUT_CYCLES = 16 + NUM_TESTS * (MAX_INS * 4 + 10);
    // op, rd, rj, rk, imm packed high to low
    localparam int INS_W = 4 + 3 * `REG_ADDR_W + `IMM_W;

    logic                   clk;
    logic                   arst_n;
    logic                   flush;
    logic                   hold;
    logic                   old_valid;
    issue_op_t              old_op;
    logic [`REG_ADDR_W-1:0] old_rd;
    logic [`REG_ADDR_W-1:0] old_rj;
    logic [`REG_ADDR_W-1:0] old_rk;
    logic [`IMM_W-1:0]      old_imm;
    logic                   young_valid;
    issue_op_t              young_op;
    logic [`REG_ADDR_W-1:0] young_rd;
    logic [`REG_ADDR_W-1:0] young_rj;
    logic [`REG_ADDR_W-1:0] young_rk;
    logic [`IMM_W-1:0]      young_imm;
    logic                   accept_old;
    logic                   accept_young;
    logic [`REG_ADDR_W-1:0] dbg_addr;
    logic [`DATA_W-1:0]     dbg_data;
    int                     pass_count;
    int                     fail_count;
    int                     issue_errs;
    int                     cycle_count = 0;
    int                     seed = 32'hd10a_5e5e;

    string                  test_name [NUM_TESTS];
    int                     test_len [NUM_TESTS];
    logic [INS_W-1:0]       test_prog [NUM_TESTS][MAX_INS];
    logic [`REG_ADDR_W-1:0] test_reg [NUM_TESTS];
    logic [`DATA_W-1:0]     test_exp [NUM_TESTS];
    bit                     test_hold [NUM_TESTS];
    logic [INS_W-1:0]       prog_q [$];

    tb_clock i_tb_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dual_issue_core i_dual_issue_core (.*);

    dual_issue_checker i_checker (.*);

    function automatic logic [INS_W-1:0] ins(issue_op_t op, int rd, int rj, int rk, int imm);
        logic [3:0] op_bits;
        op_bits = op;
        return {op_bits, rd[`REG_ADDR_W-1:0], rj[`REG_ADDR_W-1:0],
                rk[`REG_ADDR_W-1:0], imm[`IMM_W-1:0]};
    endfunction

    task automatic split(input logic [INS_W-1:0] w, output issue_op_t op,
                         output logic [`REG_ADDR_W-1:0] rd,
                         output logic [`REG_ADDR_W-1:0] rj,
                         output logic [`REG_ADDR_W-1:0] rk,
                         output logic [`IMM_W-1:0] imm);
        op = issue_op_t'(w[INS_W-1 -: 4]);
        rd = w[`IMM_W + 2 * `REG_ADDR_W +: `REG_ADDR_W];
        rj = w[`IMM_W + `REG_ADDR_W +: `REG_ADDR_W];
        rk = w[`IMM_W +: `REG_ADDR_W];
        imm = w[`IMM_W-1:0];
    endtask

    task automatic put(input int t, input issue_op_t op, input int rd, input int rj,
                       input int rk, input int imm);
        test_prog[t][test_len[t]] = ins(op, rd, rj, rk, imm);
        test_len[t] = test_len[t] + 1;
    endtask

    task automatic row(input int t, input string name, input int r,
                       input logic [`DATA_W-1:0] expected, input bit use_hold);
        test_name[t] = name;
        test_reg[t] = r[`REG_ADDR_W-1:0];
        test_exp[t] = expected;
        test_hold[t] = use_hold;
    endtask

    // expected values follow plain sequential program order
    task automatic load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_len[t] = 0;
        end
        row(0, "pair_independent", 5, 32'd10, 1'b0);
        put(0, op_addi, 1, 0, 0, 5);
        put(0, op_addi, 2, 0, 0, 7);
        put(0, op_add, 3, 1, 2, 0);
        put(0, op_xor, 4, 1, 2, 0);
        put(0, op_sub, 5, 3, 4, 0);
        row(1, "young_reads_old_rd", 3, 32'd11, 1'b0);
        put(1, op_addi, 1, 0, 0, 3);
        put(1, op_addi, 2, 1, 0, 4);
        put(1, op_addi, 2, 2, 0, 1);
        put(1, op_or, 3, 2, 1, 0);
        row(2, "young_rewrites_old_rd", 5, 32'd2, 1'b0);
        put(2, op_addi, 4, 0, 0, 9);
        put(2, op_addi, 4, 0, 0, 2);
        // r0 targets never conflict
        put(2, op_addi, 0, 0, 0, 5);
        put(2, op_addi, 0, 0, 0, 6);
        put(2, op_addi, 5, 4, 0, 0);
        row(3, "young_mul_alone", 6, 32'd84, 1'b1);
        put(3, op_addi, 1, 0, 0, 6);
        put(3, op_addi, 2, 0, 0, 7);
        put(3, op_addi, 3, 0, 0, 1);
        put(3, op_mul, 4, 1, 2, 0);
        put(3, op_addi, 5, 0, 0, 2);
        put(3, op_mul, 6, 4, 5, 0);
        row(4, "load_after_store", 4, 32'd101, 1'b0);
        put(4, op_addi, 1, 0, 0, 100);
        put(4, op_addi, 2, 0, 0, 3);
        // 3 + 18 wraps to word 5
        put(4, op_st, 1, 2, 0, 18);
        put(4, op_ld, 3, 0, 0, 5);
        put(4, op_addi, 4, 3, 0, 1);
        row(5, "mul_then_add_same_rd", 6, 32'd10, 1'b0);
        put(5, op_addi, 1, 0, 0, 4);
        put(5, op_addi, 2, 0, 0, 5);
        put(5, op_mul, 7, 1, 2, 0);
        put(5, op_ld, 8, 0, 0, 0);
        // lane write to r7 meets the first product
        put(5, op_addi, 7, 0, 0, 9);
        put(5, op_mul, 6, 7, 2, 0);
        // stage 1 write to r6 meets the second product
        put(5, op_addi, 6, 7, 0, 1);
        row(6, "random_hold_mix", 6, 32'h3d, 1'b1);
        put(6, op_addi, 1, 0, 0, 11);
        put(6, op_addi, 2, 0, 0, -3);
        put(6, op_add, 3, 1, 2, 0);
        put(6, op_mul, 4, 3, 3, 0);
        put(6, op_st, 4, 1, 0, 0);
        put(6, op_ld, 9, 3, 0, 3);
        put(6, op_sub, 5, 9, 1, 0);
        put(6, op_or, 6, 5, 3, 0);
    endtask

    task automatic present();
        old_valid = (prog_q.size() > 0);
        young_valid = (prog_q.size() > 1);
        if (old_valid) begin
            split(prog_q[0], old_op, old_rd, old_rj, old_rk, old_imm);
        end else begin
            split('0, old_op, old_rd, old_rj, old_rk, old_imm);
        end
        if (young_valid) begin
            split(prog_q[1], young_op, young_rd, young_rj, young_rk, young_imm);
        end else begin
            split('0, young_op, young_rd, young_rj, young_rk, young_imm);
        end
    endtask

    // front end advances by the accept count each cycle
    task automatic run_program(input bit use_hold);
        int n_acc;
        while (prog_q.size() > 0) begin
            @(posedge clk);
            #1;
            present();
            hold = use_hold && (($random(seed) & 3) == 0);
            @(negedge clk);
            n_acc = int'(accept_old) + int'(accept_young);
            repeat (n_acc) void'(prog_q.pop_front());
        end
        @(posedge clk);
        #1;
        present();
        hold = 1'b0;
    endtask

    task automatic clear_regs(input int t);
        issue_op_t              op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rk;
        logic [`IMM_W-1:0]      imm;
        for (int i = 0; i < test_len[t]; i++) begin
            split(test_prog[t][i], op, rd, rj, rk, imm);
            if (op != op_st) begin
                prog_q.push_back(ins(op_addi, int'(rd), 0, 0, 0));
            end
        end
        run_program(1'b0);
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the front end did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        flush = 1'b0;
        hold = 1'b0;
        dbg_addr = '0;
        present();
        load_table();
        wait (arst_n == 1'b1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            i_checker.start_test(test_name[t]);
            for (int i = 0; i < test_len[t]; i++) begin
                prog_q.push_back(test_prog[t][i]);
            end
            run_program(test_hold[t]);
            // let two-cycle results land
            repeat (4) @(posedge clk);
            #1;
            dbg_addr = test_reg[t];
            @(negedge clk);
            #1;
            i_checker.finish_test(test_reg[t], test_exp[t]);
            clear_regs(t);
        end
        $display("tests passed %0d, failed %0d, issue mismatches %0d",
                 pass_count, fail_count, issue_errs);
        if (fail_count == 0 && issue_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule
